// ==== Bender.yml ====
package:
  name: arithmetic_encoder

sources:
  - hw/enc_cfg_pkg.sv
  - hw/enc_types_pkg.sv
  - hw/sym_if.sv
  - hw/pipe_reg.sv
  - hw/enc_control.sv
  - hw/prob_scale_stage.sv
  - hw/range_update_stage.sv
  - hw/low_renorm_stage.sv
  - hw/arithmetic_encoder.sv
  - target: test
    files:
      - bench/arithmetic_encoder_tb.sv

// ==== bench/arithmetic_encoder_tb.sv ====
module arithmetic_encoder_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import enc_cfg_pkg::*;

  typedef struct packed {
    logic [15:0]       range;
    logic [23:0]       low;
    logic signed [4:0] cnt;
    logic [1:0]        flag;
    logic [15:0]       w1;
    logic [15:0]       w2;
  } exp_t;

  logic general_clk;
  logic reset;
  logic sym_valid;
  logic [15:0] fl;
  logic [15:0] fh;
  logic [3:0] symbol;
  logic [4:0] nsyms;
  logic is_bool;
  logic out_valid;
  logic busy;
  logic [15:0] range;
  logic [23:0] low;
  logic signed [4:0] cnt;
  logic [1:0] pb_flag;
  logic [15:0] pb_word_1;
  logic [15:0] pb_word_2;

  exp_t exp_q[$];
  exp_t model;
  exp_t last_seen;
  logic [31:0] rng_state;
  string test_name;
  int err_count;
  int check_count;
  int test_err_start;
  int tests_run;
  int tests_failed;
  int pulse_count;
  int one_word;
  int two_word;

  always #4 general_clk = ~general_clk;

  arithmetic_encoder dut0 (
    .general_clk (general_clk),
    .reset       (reset),
    .sym_valid   (sym_valid),
    .fl          (fl),
    .fh          (fh),
    .symbol      (symbol),
    .nsyms       (nsyms),
    .is_bool     (is_bool),
    .out_valid   (out_valid),
    .busy        (busy),
    .range       (range),
    .low         (low),
    .cnt         (cnt),
    .pb_flag     (pb_flag),
    .pb_word_1   (pb_word_1),
    .pb_word_2   (pb_word_2)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // ----------------------------------------
  // reference model, one coded symbol
  // ----------------------------------------
  function automatic exp_t ref_encode(input exp_t st, input int fl_v, input int fh_v,
                                      input int sym_v, input int ns_v, input bit bool_v);
    exp_t r;
    int rng;
    int r8;
    int u;
    int v;
    int addend;
    int nr;
    int d;
    int tmp;
    int s;
    int c;
    int cnt_v;
    longint lw;
    r = '0;
    rng = st.range;
    r8 = rng >> 8;
    if (bool_v) begin
      v = ((r8 * (fh_v >> PROB_SHIFT)) >> 1) + MIN_PROB;
      addend = (sym_v % 2 == 1) ? rng - v : 0;
      nr = (sym_v % 2 == 1) ? v : rng - v;
    end else begin
      v = ((r8 * (fh_v >> PROB_SHIFT)) >> 1) + MIN_PROB * (ns_v - 1 - sym_v);
      if (fl_v < ONE_Q15) begin
        u = ((r8 * (fl_v >> PROB_SHIFT)) >> 1) + MIN_PROB * (ns_v - 1 - (sym_v - 1));
        addend = rng - u;
        nr = u - v;
      end else begin
        addend = 0;
        nr = rng - v;
      end
    end
    // shift that brings bit 15 of the new range up
    d = 16;
    tmp = nr;
    while (tmp > 0) begin
      d--;
      tmp = tmp >> 1;
    end
    r.range = 16'(nr << d);
    lw = longint'(st.low) + addend;
    cnt_v = int'($signed(st.cnt));
    s = cnt_v + d;
    if (s < 0) begin
      cnt_v = s;
    end else begin
      c = cnt_v + 16;
      r.w1 = 16'(lw >> c);
      r.flag = 2'd1;
      if (s >= 8) begin
        lw = lw & ((longint'(1) << c) - 1);
        c = c - 8;
        r.w2 = 16'(lw >> c);
        r.flag = 2'd2;
      end
      lw = lw & ((longint'(1) << c) - 1);
      cnt_v = c + d - 24;
    end
    r.low = 24'(lw << d);
    r.cnt = 5'(cnt_v);
    return r;
  endfunction

  task automatic check_field(input string field, input int exp_v, input int act_v);
    check_count++;
    if (exp_v != act_v) begin
      err_count++;
      $display("FAILED %s %s expected %0d actual %0d", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic compare_outputs(input exp_t e);
    check_field("range", e.range, range);
    check_field("low", e.low, low);
    check_field("cnt", int'($signed(e.cnt)), int'(cnt));
    check_field("pb_flag", e.flag, pb_flag);
    check_field("pb_word_1", e.w1, pb_word_1);
    check_field("pb_word_2", e.w2, pb_word_2);
  endtask

  // outputs must match the newest result, or hold between results
  always @(negedge general_clk) begin
    if (!reset) begin
      if (out_valid) begin
        pulse_count++;
        if (exp_q.size() == 0) begin
          err_count++;
          $display("out_valid in %s with no symbol outstanding", test_name);
        end else begin
          last_seen = exp_q.pop_front();
          if (last_seen.flag == 2'd1) begin
            one_word++;
          end
          if (last_seen.flag == 2'd2) begin
            two_word++;
          end
        end
      end
      compare_outputs(last_seen);
    end
  end

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------
  task automatic send_symbol(input int fl_v, input int fh_v, input int sym_v,
                             input int ns_v, input bit bool_v);
    @(posedge general_clk);
    sym_valid <= 1'b1;
    fl <= 16'(fl_v);
    fh <= 16'(fh_v);
    symbol <= 4'(sym_v);
    nsyms <= 5'(ns_v);
    is_bool <= bool_v;
    model = ref_encode(model, fl_v, fh_v, sym_v, ns_v, bool_v);
    exp_q.push_back(model);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge general_clk);
      sym_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(negedge general_clk);
      n++;
    end while ((exp_q.size() != 0 || busy || out_valid) && n < 100);
    if (exp_q.size() != 0 || busy || out_valid) begin
      err_count++;
      $display("timeout in %s: pipeline did not drain, busy never fell", test_name);
    end
  endtask

  // single symbol with out_valid due two edges after sampling
  task automatic code_one(input int fl_v, input int fh_v, input int sym_v,
                          input int ns_v, input bit bool_v);
    int n;
    send_symbol(fl_v, fh_v, sym_v, ns_v, bool_v);
    idle_cycles(1);
    n = 0;
    do begin
      @(negedge general_clk);
      n++;
    end while (!out_valid && n < 20);
    if (!out_valid) begin
      err_count++;
      $display("timeout in %s: out_valid never came after a symbol", test_name);
    end else if (n != 3) begin
      err_count++;
      $display("FAILED %s latency expected 2 actual %0d", test_name, n - 1);
    end
    wait_drain();
  endtask

  // bool or multi-symbol taken from a random decreasing icdf
  task automatic random_symbol();
    int ns;
    int sym;
    int cur;
    int nxt;
    int slack;
    int fl_v;
    int fh_v;
    if (rand_next() % 4 == 0) begin
      fh_v = rand_next() % 32705;
      send_symbol(ONE_Q15, fh_v, rand_next() % 2, 2, 1'b1);
    end else begin
      ns = 2 + rand_next() % 15;
      sym = rand_next() % ns;
      cur = ONE_Q15;
      fl_v = ONE_Q15;
      fh_v = 0;
      for (int i = 0; i <= sym; i++) begin
        if (i == ns - 1) begin
          nxt = 0;
        end else begin
          slack = cur - 64 * (ns - i);
          nxt = cur - 64 - rand_next() % (slack + 1);
        end
        fl_v = cur;
        fh_v = nxt;
        cur = nxt;
      end
      send_symbol(fl_v, fh_v, sym, ns, 1'b0);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_start = err_count;
    pulse_count = 0;
    one_word = 0;
    two_word = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count != test_err_start) begin
      tests_failed++;
      $display("test %s done with %0d errors", test_name, err_count - test_err_start);
    end else begin
      $display("test %s done, ok", test_name);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    general_clk = 1'b0;
    reset = 1'b1;
    sym_valid = 1'b0;
    fl = '0;
    fh = '0;
    symbol = '0;
    nsyms = '0;
    is_bool = 1'b0;
    rng_state = 32'h2298;
    err_count = 0;
    check_count = 0;
    tests_run = 0;
    tests_failed = 0;
    model = '0;
    model.range = 16'(RANGE_INIT);
    model.cnt = 5'(CNT_INIT);
    last_seen = model;

    begin_test("reset_state");
    repeat (16) @(posedge general_clk);
    reset <= 1'b0;
    @(negedge general_clk);
    check_field("out_valid", 0, out_valid);
    check_field("busy", 0, busy);
    compare_outputs(model);
    end_test();

    begin_test("multi_symbol");
    code_one(32768, 24000, 0, 4, 1'b0);
    code_one(24000, 12000, 1, 4, 1'b0);
    code_one(4000, 0, 3, 4, 1'b0);
    end_test();

    begin_test("bool_path");
    code_one(32768, 2000, 0, 2, 1'b1);
    code_one(32768, 2000, 1, 2, 1'b1);
    code_one(32768, 30000, 0, 2, 1'b1);
    code_one(32768, 30000, 1, 2, 1'b1);
    end_test();

    begin_test("random_stream");
    repeat (300) random_symbol();
    idle_cycles(1);
    wait_drain();
    if (one_word == 0 || two_word == 0) begin
      err_count++;
      $display("random_stream did not see both one-word and two-word emissions");
    end
    end_test();

    begin_test("idle_gaps");
    repeat (59) begin
      random_symbol();
      idle_cycles(rand_next() % 5);
    end
    random_symbol();
    idle_cycles(1);
    @(negedge general_clk);
    if (!busy) begin
      err_count++;
      $display("idle_gaps: busy low while the last symbol was in flight");
    end
    wait_drain();
    check_field("out_valid pulses", 60, pulse_count);
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/enc_cfg_pkg.sv
hw/enc_types_pkg.sv
hw/sym_if.sv
hw/pipe_reg.sv
hw/enc_control.sv
hw/prob_scale_stage.sv
hw/range_update_stage.sv
hw/low_renorm_stage.sv
hw/arithmetic_encoder.sv
bench/arithmetic_encoder_tb.sv

// ==== hw/arithmetic_encoder.sv ====
module arithmetic_encoder (
  input  logic                                   general_clk,
  input  logic                                   reset,
  input  logic                                   sym_valid,
  input  logic [enc_cfg_pkg::RANGE_WIDTH-1:0]    fl,
  input  logic [enc_cfg_pkg::RANGE_WIDTH-1:0]    fh,
  input  logic [enc_cfg_pkg::SYMBOL_WIDTH-1:0]   symbol,
  input  logic [enc_cfg_pkg::SYMBOL_WIDTH:0]     nsyms,
  input  logic                                   is_bool,
  output logic                                   out_valid,
  output logic                                   busy,
  output logic [enc_cfg_pkg::RANGE_WIDTH-1:0]    range,
  output logic [enc_cfg_pkg::LOW_WIDTH-1:0]      low,
  output logic signed [enc_cfg_pkg::D_SIZE-1:0]  cnt,
  output logic [1:0]                             pb_flag,
  output logic [enc_cfg_pkg::RANGE_WIDTH-1:0]    pb_word_1,
  output logic [enc_cfg_pkg::RANGE_WIDTH-1:0]    pb_word_2
);

  import enc_types_pkg::*;

  logic en_12;
  logic en_23;
  logic en_out;
  s12_t s12_d;
  s12_t s12_q;
  s23_t s23_d;
  s23_t s23_q;

  sym_if sym ();

  assign sym.valid   = sym_valid;
  assign sym.fl      = fl;
  assign sym.fh      = fh;
  assign sym.symbol  = symbol;
  assign sym.nsyms   = nsyms;
  assign sym.is_bool = is_bool;

  enc_control u_control (
    .general_clk (general_clk),
    .reset       (reset),
    .sym         (sym),
    .en_12       (en_12),
    .en_23       (en_23),
    .en_out      (en_out),
    .out_valid   (out_valid),
    .busy        (busy)
  );

  // ----------------------------------------
  // stage 1
  // ----------------------------------------
  prob_scale_stage u_stage_1 (
    .sym (sym),
    .out (s12_d)
  );

  pipe_reg #(.payload_t(s12_t)) u_reg_12 (
    .general_clk (general_clk),
    .en          (en_12),
    .d           (s12_d),
    .q           (s12_q)
  );

  // ----------------------------------------
  // stage 2
  // ----------------------------------------
  range_update_stage u_stage_2 (
    .general_clk (general_clk),
    .reset       (reset),
    .en          (en_23),
    .in          (s12_q),
    .out         (s23_d),
    .range       (range)
  );

  pipe_reg #(.payload_t(s23_t)) u_reg_23 (
    .general_clk (general_clk),
    .en          (en_23),
    .d           (s23_d),
    .q           (s23_q)
  );

  // stage 3
  low_renorm_stage u_stage_3 (
    .general_clk (general_clk),
    .reset       (reset),
    .en          (en_out),
    .in          (s23_q),
    .low         (low),
    .cnt         (cnt),
    .pb_flag     (pb_flag),
    .pb_word_1   (pb_word_1),
    .pb_word_2   (pb_word_2)
  );

endmodule

// ==== hw/enc_cfg_pkg.sv ====
package enc_cfg_pkg;

  // ----------------------------------------
  // coder widths
  // ----------------------------------------
  localparam int RANGE_WIDTH  = 16;
  localparam int LOW_WIDTH    = 24;
  localparam int SYMBOL_WIDTH = 4;
  localparam int D_SIZE       = 5;

  // ----------------------------------------
  // coding constants
  // ----------------------------------------
  localparam int PROB_SHIFT = 6;
  localparam int MIN_PROB   = 4;
  localparam int RANGE_INIT = 32768;
  localparam int CNT_INIT   = -9;

  // icdf value meaning no lower bound
  localparam int ONE_Q15 = 32768;

endpackage

// ==== hw/enc_control.sv ====
module enc_control (
  input  logic general_clk,
  input  logic reset,
  sym_if.ctrl  sym,
  output logic en_12,
  output logic en_23,
  output logic en_out,
  output logic out_valid,
  output logic busy
);

  // token[0] sits in stage 2, token[1] in stage 3
  logic [1:0] token;

  always_ff @(posedge general_clk) begin
    if (reset) begin
      token     <= '0;
      out_valid <= 1'b0;
    end else begin
      token     <= {token[0], sym.valid};
      out_valid <= token[1];
    end
  end

  // stage 1 capture follows the input strobe directly
  assign en_12  = sym.valid;
  assign en_23  = token[0];
  assign en_out = token[1];

  // any symbol still between the pipeline registers
  assign busy = |token;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_out_valid_from_en_out : assert property (
    @(posedge general_clk) disable iff (reset)
    $rose(out_valid) |-> $past(en_out)
  ) else $error("out_valid rose without a token in stage 3");

endmodule

// ==== hw/enc_types_pkg.sv ====
package enc_types_pkg;

  import enc_cfg_pkg::*;

  // 32768 >> 6 needs 10 bits
  localparam int PROB_WIDTH = RANGE_WIDTH - PROB_SHIFT;
  // largest offset is MIN_PROB * 16
  localparam int OFF_WIDTH  = $clog2(MIN_PROB << SYMBOL_WIDTH) + 1;
  localparam int D_WIDTH    = $clog2(RANGE_WIDTH);

  // ----------------------------------------
  // stage 1 -> stage 2
  // ----------------------------------------
  typedef struct packed {
    logic [PROB_WIDTH-1:0] uu;
    logic [PROB_WIDTH-1:0] vv;
    logic [OFF_WIDTH-1:0]  off_u;
    logic [OFF_WIDTH-1:0]  off_v;
    logic                  has_low;
    logic                  is_bool;
    logic                  bit_val;
  } s12_t;

  // ----------------------------------------
  // stage 2 -> stage 3
  // ----------------------------------------
  typedef struct packed {
    logic [RANGE_WIDTH-1:0] addend;
    logic [D_WIDTH-1:0]     d;
  } s23_t;

endpackage

// ==== hw/low_renorm_stage.sv ====
module low_renorm_stage (
  input  logic                                      general_clk,
  input  logic                                      reset,
  input  logic                                      en,
  input  enc_types_pkg::s23_t                       in,
  output logic [enc_cfg_pkg::LOW_WIDTH-1:0]         low,
  output logic signed [enc_cfg_pkg::D_SIZE-1:0]     cnt,
  output logic [1:0]                                pb_flag,
  output logic [enc_cfg_pkg::RANGE_WIDTH-1:0]       pb_word_1,
  output logic [enc_cfg_pkg::RANGE_WIDTH-1:0]       pb_word_2
);

  import enc_cfg_pkg::*;

  logic [LOW_WIDTH:0]         low_work;
  logic signed [D_SIZE:0]     cnt_ext;
  logic signed [D_SIZE:0]     d_ext;
  logic signed [D_SIZE:0]     s_sum;
  logic signed [D_SIZE:0]     c_cur;
  logic signed [D_SIZE:0]     cnt_calc;
  logic [1:0]                 flag_nxt;
  logic [RANGE_WIDTH-1:0]     word_1_nxt;
  logic [RANGE_WIDTH-1:0]     word_2_nxt;
  logic [LOW_WIDTH-1:0]       low_nxt;

  // keep the lower n bits
  function automatic logic [LOW_WIDTH:0] keep_bits(input logic [LOW_WIDTH:0] v,
                                                   input logic [3:0]         n);
    return v & (((LOW_WIDTH+1)'(1) << n) - 1'b1);
  endfunction

  // ----------------------------------------
  // low update and word emission
  // ----------------------------------------
  always_comb begin
    low_work   = {1'b0, low} + (LOW_WIDTH+1)'(in.addend);
    cnt_ext    = cnt;
    d_ext      = signed'({2'b00, in.d});
    s_sum      = cnt_ext + d_ext;
    c_cur      = cnt_ext + 6'sd16;
    flag_nxt   = 2'd0;
    word_1_nxt = '0;
    word_2_nxt = '0;
    cnt_calc   = s_sum;

    if (s_sum >= 0) begin
      word_1_nxt = RANGE_WIDTH'(low_work >> c_cur[3:0]);
      flag_nxt   = 2'd1;
      if (s_sum >= 8) begin
        low_work   = keep_bits(low_work, c_cur[3:0]);
        c_cur      = c_cur - 6'sd8;
        word_2_nxt = RANGE_WIDTH'(low_work >> c_cur[3:0]);
        flag_nxt   = 2'd2;
      end
      low_work = keep_bits(low_work, c_cur[3:0]);
      cnt_calc = c_cur + d_ext - 6'sd24;
    end

    low_nxt = LOW_WIDTH'(low_work << in.d);
  end

  always_ff @(posedge general_clk) begin
    if (reset) begin
      low       <= '0;
      cnt       <= D_SIZE'(CNT_INIT);
      pb_flag   <= 2'd0;
      pb_word_1 <= '0;
      pb_word_2 <= '0;
    end else if (en) begin
      low       <= low_nxt;
      cnt       <= cnt_calc[D_SIZE-1:0];
      pb_flag   <= flag_nxt;
      pb_word_1 <= word_1_nxt;
      pb_word_2 <= word_2_nxt;
    end
  end

  // count stays negative between symbols
  a_cnt_negative : assert property (
    @(posedge general_clk) disable iff (reset) en |=> (cnt < 0)
  ) else $error("bit count not negative after an update");

endmodule

// ==== hw/pipe_reg.sv ====
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     general_clk,
  input  logic     en,
  input  payload_t d,
  output payload_t q
);

  // validity travels with the control token
  always_ff @(posedge general_clk) begin
    if (en) begin
      q <= d;
    end
  end

endmodule

// ==== hw/prob_scale_stage.sv ====
module prob_scale_stage (
  sym_if.stage                sym,
  output enc_types_pkg::s12_t out
);

  import enc_cfg_pkg::*;
  import enc_types_pkg::*;

  // nsyms - 1 - (symbol - 1) and nsyms - 1 - symbol
  logic [SYMBOL_WIDTH:0] span_u;
  logic [SYMBOL_WIDTH:0] span_v;

  always_comb begin
    span_u = sym.nsyms - {1'b0, sym.symbol};
    span_v = span_u - 1'b1;

    out.uu      = sym.fl[RANGE_WIDTH-1:PROB_SHIFT];
    out.vv      = sym.fh[RANGE_WIDTH-1:PROB_SHIFT];
    out.is_bool = sym.is_bool;

    if (sym.is_bool) begin
      // bool takes fh as its probability
      out.has_low = 1'b0;
      out.off_u   = '0;
      out.off_v   = OFF_WIDTH'(MIN_PROB);
      out.bit_val = sym.symbol[0];
    end else begin
      out.has_low = (sym.fl < ONE_Q15);
      out.off_u   = OFF_WIDTH'(MIN_PROB * span_u);
      out.off_v   = OFF_WIDTH'(MIN_PROB * span_v);
      out.bit_val = 1'b0;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // icdf must decrease across the coded symbol
  always_comb begin
    if (sym.valid && !sym.is_bool && (sym.fl < ONE_Q15)) begin
      a_icdf_order : assert #0 (sym.fl > sym.fh)
        else $error("fl not above fh for a multi-symbol input");
    end
  end

endmodule

// ==== hw/range_update_stage.sv ====
module range_update_stage (
  input  logic                                general_clk,
  input  logic                                reset,
  input  logic                                en,
  input  enc_types_pkg::s12_t                 in,
  output enc_types_pkg::s23_t                 out,
  output logic [enc_cfg_pkg::RANGE_WIDTH-1:0] range
);

  import enc_cfg_pkg::*;
  import enc_types_pkg::*;

  logic [RANGE_WIDTH-1:0] range_q;
  logic [RANGE_WIDTH-1:0] u_val;
  logic [RANGE_WIDTH-1:0] v_val;
  logic [RANGE_WIDTH-1:0] new_range;

  // (top 8 bits of range * p) >> 1
  function automatic logic [RANGE_WIDTH-1:0] scale(input logic [RANGE_WIDTH-1:0] r,
                                                   input logic [PROB_WIDTH-1:0]  p);
    logic [RANGE_WIDTH+1:0] prod;
    prod = r[RANGE_WIDTH-1 -: RANGE_WIDTH/2] * p;
    return RANGE_WIDTH'(prod >> 1);
  endfunction

  // leading zero count of a nonzero range
  function automatic logic [D_WIDTH-1:0] norm_shift(input logic [RANGE_WIDTH-1:0] r);
    logic [D_WIDTH-1:0] n;
    n = '0;
    for (int i = 0; i < RANGE_WIDTH; i++) begin
      if (r[i]) begin
        n = D_WIDTH'(RANGE_WIDTH - 1 - i);
      end
    end
    return n;
  endfunction

  always_comb begin
    u_val = scale(range_q, in.uu) + RANGE_WIDTH'(in.off_u);
    // off_v is MIN_PROB for a bool
    v_val = scale(range_q, in.vv) + RANGE_WIDTH'(in.off_v);

    if (in.is_bool) begin
      out.addend = in.bit_val ? (range_q - v_val) : '0;
      new_range  = in.bit_val ? v_val : (range_q - v_val);
    end else if (in.has_low) begin
      out.addend = range_q - u_val;
      new_range  = u_val - v_val;
    end else begin
      out.addend = '0;
      new_range  = range_q - v_val;
    end

    out.d = norm_shift(new_range);
  end

  always_ff @(posedge general_clk) begin
    if (reset) begin
      range_q <= RANGE_WIDTH'(RANGE_INIT);
      range   <= RANGE_WIDTH'(RANGE_INIT);
    end else begin
      if (en) begin
        range_q <= new_range << out.d;
      end
      // output copy lags one cycle to line up with low and cnt
      range <= range_q;
    end
  end

  a_range_normalized : assert property (
    @(posedge general_clk) disable iff (reset) range_q[RANGE_WIDTH-1]
  ) else $error("stored range lost its top bit");

endmodule

// ==== hw/sym_if.sv ====
interface sym_if;

  logic                                valid;
  logic [enc_cfg_pkg::RANGE_WIDTH-1:0] fl;
  logic [enc_cfg_pkg::RANGE_WIDTH-1:0] fh;
  logic [enc_cfg_pkg::SYMBOL_WIDTH-1:0] symbol;
  logic [enc_cfg_pkg::SYMBOL_WIDTH:0]  nsyms;
  logic                                is_bool;

  // top level side
  modport src (output valid, fl, fh, symbol, nsyms, is_bool);

  // stage 1 reads all fields
  modport stage (input valid, fl, fh, symbol, nsyms, is_bool);

  // token generation only needs the strobe
  modport ctrl (input valid);

endinterface
